/* Makefile */
VERILATOR  := verilator
VFLAGS     := --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS := --lint-only --timing --timescale 1ns/1ps
TB_TOP     := tb_digital_core
RTL_TOP    := digital_core
FILELIST   := digital_core.f
SIM_ARGS   := +verilator+error+limit+1000
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TB_TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "Result: PASSED" $(LOG) || { echo "Simulation did not complete"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* digital_core.f */
+incdir+include
src/digital_core_pkg.sv
src/wb_intercon.sv
src/glbl_cfg.sv
src/digital_core.sv
tb/digital_core_checker.sv
tb/tb_digital_core.sv

/* include/digital_core_params.svh */
// Bus widths, address map, register offsets and reset values for the digital core
`ifndef DIGITAL_CORE_PARAMS_SVH
`define DIGITAL_CORE_PARAMS_SVH

// ------------------------------
// Wishbone bus
// ------------------------------
`define WB_WIDTH        32              // Data and address width
`define WB_SEL_W        4               // One enable per byte

// ------------------------------
// Address map
// ------------------------------
// Top nibble of the address picks the target, only one window is decoded
`define GLBL_BASE_NIB   4'h3            // Register bank window
`define REG_ADDR_W      4               // Word offset, address bits 5:2

// ------------------------------
// Register reset values
// ------------------------------
`define DEVICE_IDCODE   32'h5946_0001   // Read-only device id
`define HARTID_RST      32'h0           // Hart id after reset

// Block side widths
`define USER_IRQ_W      3               // User interrupt lines

`endif

/* src/digital_core.sv */
// Digital core top level: Wishbone decoder and global configuration register bank
`timescale 1ns/1ps
`include "digital_core_params.svh"

module digital_core (
    input  logic                       wb_clk_i,       // System clock
    input  logic                       rst_n_i,        // Sync reset, active low

    // External Wishbone master
    input  logic                       wbd_ext_cyc_i,  // Bus cycle
    input  logic                       wbd_ext_stb_i,  // Strobe/request
    input  logic                       wbd_ext_we_i,   // Write
    input  digital_core_pkg::wb_addr_t wbd_ext_adr_i,  // Address
    input  digital_core_pkg::wb_data_t wbd_ext_dat_i,  // Write data
    input  digital_core_pkg::wb_sel_t  wbd_ext_sel_i,  // Byte enable
    output digital_core_pkg::wb_data_t wbd_ext_dat_o,  // Read data
    output logic                       wbd_ext_ack_o,  // Acknowledge
    output logic                       wbd_ext_err_o,  // Error

    // Block resets and interrupts
    output logic                       cpu_rst_n_o,
    output logic                       spi_rst_n_o,
    output logic                       sdram_rst_n_o,
    output logic [`USER_IRQ_W-1:0]     user_irq_o
);
    import digital_core_pkg::*;

    // ------------------------------
    // Register bus
    // ------------------------------
    logic      reg_cs;
    logic      reg_wr;
    reg_addr_t reg_addr;
    wb_data_t  reg_wdata;
    wb_sel_t   reg_be;
    wb_data_t  reg_rdata;
    logic      reg_ack;

    wb_intercon u_intercon (
        .wb_clk_i    (wb_clk_i      ),
        .rst_n_i     (rst_n_i       ),
        .wbd_cyc_i   (wbd_ext_cyc_i ),
        .wbd_stb_i   (wbd_ext_stb_i ),
        .wbd_we_i    (wbd_ext_we_i  ),
        .wbd_adr_i   (wbd_ext_adr_i ),
        .wbd_dat_i   (wbd_ext_dat_i ),
        .wbd_sel_i   (wbd_ext_sel_i ),
        .wbd_dat_o   (wbd_ext_dat_o ),
        .wbd_ack_o   (wbd_ext_ack_o ),
        .wbd_err_o   (wbd_ext_err_o ),
        .reg_cs_o    (reg_cs        ),
        .reg_wr_o    (reg_wr        ),
        .reg_addr_o  (reg_addr      ),
        .reg_wdata_o (reg_wdata     ),
        .reg_be_o    (reg_be        ),
        .reg_rdata_i (reg_rdata     ),
        .reg_ack_i   (reg_ack       )
    );

    // Global config, owns the block reset levels
    glbl_cfg u_glbl_cfg (
        .wb_clk_i      (wb_clk_i      ),
        .rst_n_i       (rst_n_i       ),
        .reg_cs_i      (reg_cs        ),
        .reg_wr_i      (reg_wr        ),
        .reg_addr_i    (reg_addr      ),
        .reg_wdata_i   (reg_wdata     ),
        .reg_be_i      (reg_be        ),
        .reg_rdata_o   (reg_rdata     ),
        .reg_ack_o     (reg_ack       ),
        .cpu_rst_n_o   (cpu_rst_n_o   ),
        .spi_rst_n_o   (spi_rst_n_o   ),
        .sdram_rst_n_o (sdram_rst_n_o ),
        .user_irq_o    (user_irq_o    )
    );

endmodule : digital_core

/* src/digital_core_pkg.sv */
// Wishbone data, address, byte-enable and register offset types for the core
`include "digital_core_params.svh"

package digital_core_pkg;

    // ------------------------------
    // Wishbone bus types
    // ------------------------------
    typedef logic [`WB_WIDTH-1:0]   wb_data_t;  // One data word
    typedef logic [`WB_WIDTH-1:0]   wb_addr_t;  // Byte address
    typedef logic [`WB_SEL_W-1:0]   wb_sel_t;   // Byte enables

    // Word offset inside the register bank
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // ------------------------------
    // Global register offsets
    // ------------------------------
    typedef enum logic [`REG_ADDR_W-1:0] {
        GLBL_CTRL   = 4'd0,   // Block resets, active low
        GLBL_IRQ    = 4'd1,   // User interrupt lines
        GLBL_HARTID = 4'd2,   // Hart id, read and write
        GLBL_IDCODE = 4'd3    // Device id, read only
    } glbl_reg_e;

    // Control register bit positions
    // bit 0 cpu, bit 1 spi, bit 2 sdram

endpackage : digital_core_pkg

/* src/glbl_cfg.sv */
// Global configuration registers: block resets, user interrupts, hart id and device id
`timescale 1ns/1ps
`include "digital_core_params.svh"

module glbl_cfg (
    input  logic                        wb_clk_i,      // System clock
    input  logic                        rst_n_i,       // Sync reset, active low

    // Register bus from decoder
    input  logic                        reg_cs_i,      // Access this cycle
    input  logic                        reg_wr_i,      // 1 write, 0 read
    input  digital_core_pkg::reg_addr_t reg_addr_i,    // Word offset
    input  digital_core_pkg::wb_data_t  reg_wdata_i,
    input  digital_core_pkg::wb_sel_t   reg_be_i,
    output digital_core_pkg::wb_data_t  reg_rdata_o,   // Valid with ack
    output logic                        reg_ack_o,

    // Block controls
    output logic                        cpu_rst_n_o,
    output logic                        spi_rst_n_o,
    output logic                        sdram_rst_n_o,
    output logic [`USER_IRQ_W-1:0]      user_irq_o
);
    import digital_core_pkg::*;

    localparam int CTRL_W = 3;  // cpu, spi, sdram

    logic [CTRL_W-1:0]      ctrl_q;     // Reset levels
    logic [`USER_IRQ_W-1:0] irq_q;      // Interrupt lines
    wb_data_t               hartid_q;
    glbl_reg_e              reg_sel;
    logic                   wr_en;
    wb_data_t               ctrl_ext;   // Registers seen as bus words
    wb_data_t               irq_ext;
    wb_data_t               ctrl_nxt;   // Write data merged per byte
    wb_data_t               irq_nxt;
    wb_data_t               hartid_nxt;
    wb_data_t               rd_mux;

    // Replace only the enabled bytes of the current value
    function automatic wb_data_t be_merge(
        input wb_data_t cur,
        input wb_data_t wdata,
        input wb_sel_t  be
    );
        wb_data_t res;
        res = cur;
        for (int i = 0; i < `WB_SEL_W; i++) begin
            if (be[i]) begin
                res[8*i +: 8] = wdata[8*i +: 8];
            end
        end
        return res;
    endfunction

    // ------------------------------
    // Write path
    // ------------------------------
    assign reg_sel  = glbl_reg_e'(reg_addr_i);
    assign wr_en    = reg_cs_i & reg_wr_i;

    assign ctrl_ext = {{(`WB_WIDTH-CTRL_W){1'b0}}, ctrl_q};
    assign irq_ext  = {{(`WB_WIDTH-`USER_IRQ_W){1'b0}}, irq_q};

    assign ctrl_nxt   = be_merge(ctrl_ext, reg_wdata_i, reg_be_i);
    assign irq_nxt    = be_merge(irq_ext, reg_wdata_i, reg_be_i);
    assign hartid_nxt = be_merge(hartid_q, reg_wdata_i, reg_be_i);

    // Write lands on the same edge as the ack
    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            ctrl_q   <= '0;            // All blocks held in reset
            irq_q    <= '0;
            hartid_q <= `HARTID_RST;
        end else if (wr_en) begin
            case (reg_sel)
                GLBL_CTRL:   ctrl_q   <= ctrl_nxt[CTRL_W-1:0];
                GLBL_IRQ:    irq_q    <= irq_nxt[`USER_IRQ_W-1:0];
                GLBL_HARTID: hartid_q <= hartid_nxt;
                default: begin
                    // IDCODE and unused offsets take no write
                end
            endcase
        end
    end

    // ------------------------------
    // Read path
    // ------------------------------
    always_comb begin
        case (reg_sel)
            GLBL_CTRL:   rd_mux = ctrl_ext;
            GLBL_IRQ:    rd_mux = irq_ext;
            GLBL_HARTID: rd_mux = hartid_q;
            GLBL_IDCODE: rd_mux = `DEVICE_IDCODE;
            default:     rd_mux = '0;  // Unused offset reads zero
        endcase
    end

    // Ack one cycle after select
    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            reg_ack_o <= 1'b0;
        end else begin
            reg_ack_o <= reg_cs_i;
        end
    end

    // Readback captured with the access, old value on a write
    always_ff @(posedge wb_clk_i) begin
        if (reg_cs_i) begin
            reg_rdata_o <= rd_mux;
        end
    end

    // ------------------------------
    // Block controls
    // ------------------------------
    assign cpu_rst_n_o   = ctrl_q[0];  // Low holds cpu in reset
    assign spi_rst_n_o   = ctrl_q[1];
    assign sdram_rst_n_o = ctrl_q[2];
    assign user_irq_o    = irq_q;

endmodule : glbl_cfg

/* src/wb_intercon.sv */
// Wishbone address decoder with register bank select and unmapped error response
`timescale 1ns/1ps
`include "digital_core_params.svh"

module wb_intercon (
    input  logic                        wb_clk_i,     // System clock
    input  logic                        rst_n_i,      // Sync reset, active low

    // External master side
    input  logic                        wbd_cyc_i,    // Bus cycle
    input  logic                        wbd_stb_i,    // Strobe/request
    input  logic                        wbd_we_i,     // Write
    input  digital_core_pkg::wb_addr_t  wbd_adr_i,    // Address
    input  digital_core_pkg::wb_data_t  wbd_dat_i,    // Write data
    input  digital_core_pkg::wb_sel_t   wbd_sel_i,    // Byte enable
    output digital_core_pkg::wb_data_t  wbd_dat_o,    // Read data
    output logic                        wbd_ack_o,    // Acknowledge
    output logic                        wbd_err_o,    // Error

    // Register bank side
    output logic                        reg_cs_o,
    output logic                        reg_wr_o,
    output digital_core_pkg::reg_addr_t reg_addr_o,
    output digital_core_pkg::wb_data_t  reg_wdata_o,
    output digital_core_pkg::wb_sel_t   reg_be_o,
    input  digital_core_pkg::wb_data_t  reg_rdata_i,
    input  logic                        reg_ack_i
);
    import digital_core_pkg::*;

    logic     req;        // Master request active
    logic     hit_glbl;   // Address inside bank window
    logic     accept;     // New request taken this cycle
    logic     pending_q;  // Response in flight
    logic     unmap_q;    // Decoder's own error path
    wb_data_t rsp_data;   // Data for the master

    // ------------------------------
    // Address decode
    // ------------------------------
    assign req      = wbd_cyc_i & wbd_stb_i;
    assign hit_glbl = (wbd_adr_i[`WB_WIDTH-1 -: 4] == `GLBL_BASE_NIB);
    assign accept   = req & ~pending_q;  // One transaction at a time

    // Request straight through to the bank
    assign reg_cs_o    = accept & hit_glbl;
    assign reg_wr_o    = wbd_we_i;
    assign reg_addr_o  = wbd_adr_i[`REG_ADDR_W+1:2];  // Word offset
    assign reg_wdata_o = wbd_dat_i;
    assign reg_be_o    = wbd_sel_i;

    // Pending stays up until the master drops its strobe,
    // so a held request is not taken twice
    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            pending_q <= 1'b0;
        end else if (accept) begin
            pending_q <= 1'b1;
        end else if (!req) begin
            pending_q <= 1'b0;
        end
    end

    // Unmapped access, answered here one cycle after the request
    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            unmap_q <= 1'b0;
        end else begin
            unmap_q <= accept & ~hit_glbl;
        end
    end

    // ------------------------------
    // Response register
    // ------------------------------
    assign rsp_data = reg_ack_i ? reg_rdata_i : '0;  // Zero on error

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            wbd_ack_o <= 1'b0;
            wbd_err_o <= 1'b0;
        end else begin
            wbd_ack_o <= reg_ack_i;  // Single pulse from the bank
            wbd_err_o <= unmap_q;
        end
    end

    // Read data loads with each response and holds after it
    always_ff @(posedge wb_clk_i) begin
        if (reg_ack_i | unmap_q) begin
            wbd_dat_o <= rsp_data;
        end
    end

endmodule : wb_intercon

/* tb/digital_core_checker.sv */
// Bound assertions on Wishbone response timing and block reset state
`timescale 1ns/1ps
`include "digital_core_params.svh"

module digital_core_checker (
    input logic                   clk_i,
    input logic                   rst_n_i,
    input logic                   cyc_i,
    input logic                   stb_i,
    input logic                   we_i,
    input logic                   ack_i,
    input logic                   err_i,
    input logic                   cpu_rst_n_i,
    input logic                   spi_rst_n_i,
    input logic                   sdram_rst_n_i,
    input logic [`USER_IRQ_W-1:0] user_irq_i
);
    logic req;
    logic rsp;
    logic req_q;
    logic start_q;      // Request started one edge ago
    logic start_qq;     // ... two edges ago
    logic wrote_q;      // Any write seen since reset
    int   fail_cnt;

    assign req = cyc_i & stb_i;
    assign rsp = ack_i | err_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            req_q    <= 1'b0;
            start_q  <= 1'b0;
            start_qq <= 1'b0;
            wrote_q  <= 1'b0;
        end else begin
            req_q    <= req;
            start_q  <= req & ~req_q;
            start_qq <= start_q;
            if (req & we_i) wrote_q <= 1'b1;
        end
    end

    initial fail_cnt = 0;

    a_ack_err_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(ack_i && err_i))
        else begin $error("ack and err high together"); fail_cnt++; end

    a_rsp_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rsp |=> !rsp)
        else begin $error("response longer than one cycle"); fail_cnt++; end

    // Response exactly on the second edge after stb rises
    a_rsp_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        start_qq == rsp)
        else begin $error("response not two cycles after stb"); fail_cnt++; end

    a_reset_state: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !wrote_q |-> (!cpu_rst_n_i && !spi_rst_n_i && !sdram_rst_n_i && user_irq_i == '0))
        else begin $error("block controls left reset state before a write"); fail_cnt++; end

endmodule : digital_core_checker

bind digital_core digital_core_checker u_checker (
    .clk_i         (wb_clk_i     ),
    .rst_n_i       (rst_n_i      ),
    .cyc_i         (wbd_ext_cyc_i),
    .stb_i         (wbd_ext_stb_i),
    .we_i          (wbd_ext_we_i ),
    .ack_i         (wbd_ext_ack_o),
    .err_i         (wbd_ext_err_o),
    .cpu_rst_n_i   (cpu_rst_n_o  ),
    .spi_rst_n_i   (spi_rst_n_o  ),
    .sdram_rst_n_i (sdram_rst_n_o),
    .user_irq_i    (user_irq_o   )
);

/* tb/digital_core_stim.txt */
# op addr data sel exp_data exp_err   (W write, R read, Q random write, M read vs model)
# P checks block ports, exp_data = user_irq in bits 6:4 and sdram, spi, cpu resets in 2:0
P 00000000 00000000 0 00000000 0
R 30000008 00000000 f 00000000 0
W 30000000 00000005 1 00000000 0
P 00000000 00000000 0 00000005 0
R 30000000 00000000 f 00000005 0
W 30000000 000000fe e 00000000 0
W 30000004 00000006 f 00000000 0
P 00000000 00000000 0 00000065 0
W 30000008 a5a5a5a5 f 00000000 0
W 30000008 11223344 5 00000000 0
R 30000008 00000000 f a522a544 0
Q 30000008 00000000 6 00000000 0
M 30000008 00000000 f 00000000 0
W 3000000c deadbeef f 00000000 0
R 3000000c 00000000 f 59460001 0
R 30000010 00000000 f 00000000 0
W 10000000 00000000 f 00000000 1
W f0000008 ffffffff f 00000000 1
R 40000004 00000000 f 00000000 1
M 30000008 00000000 f 00000000 0
P 00000000 00000000 0 00000065 0

/* tb/tb_digital_core.sv */
// Testbench for the digital core: clock, reset, stimulus file, bus driver, checks, watchdog
`timescale 1ns/1ps
`include "digital_core_params.svh"

module tb_digital_core;
    import digital_core_pkg::*;

    localparam int CLK_HALF    = 50;    // 100 ns period
    localparam int RST_CYCLES  = 3;
    localparam int RSP_LIMIT   = 8;     // Driver gives up after this many edges
    localparam int LINE_BUDGET = 20;    // Watchdog cycles per stimulus line

    logic                   clk;
    logic                   rst_n;
    logic                   cyc;
    logic                   stb;
    logic                   we;
    wb_addr_t               adr;
    wb_data_t               dat_w;
    wb_sel_t                sel;
    wb_data_t               dat_r;
    logic                   ack;
    logic                   err;
    logic                   cpu_rst_n;
    logic                   spi_rst_n;
    logic                   sdram_rst_n;
    logic [`USER_IRQ_W-1:0] user_irq;

    // Stimulus, one entry per file line
    byte       op_q[$];
    wb_addr_t  adr_q[$];
    wb_data_t  dat_q[$];
    wb_sel_t   sel_q[$];
    wb_data_t  exp_q[$];
    logic      eerr_q[$];

    int        n_lines;
    int        n_checks;
    int        n_errors;
    bit        loaded;
    integer    seed;
    wb_data_t  ctrl_m;      // Register model
    wb_data_t  irq_m;
    wb_data_t  hartid_m;

    digital_core DUT (
        .wb_clk_i      (clk        ),
        .rst_n_i       (rst_n      ),
        .wbd_ext_cyc_i (cyc        ),
        .wbd_ext_stb_i (stb        ),
        .wbd_ext_we_i  (we         ),
        .wbd_ext_adr_i (adr        ),
        .wbd_ext_dat_i (dat_w      ),
        .wbd_ext_sel_i (sel        ),
        .wbd_ext_dat_o (dat_r      ),
        .wbd_ext_ack_o (ack        ),
        .wbd_ext_err_o (err        ),
        .cpu_rst_n_o   (cpu_rst_n  ),
        .spi_rst_n_o   (spi_rst_n  ),
        .sdram_rst_n_o (sdram_rst_n),
        .user_irq_o    (user_irq   )
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_HALF) clk = ~clk;
    end

    task automatic check_val(input string name, input wb_data_t got, input wb_data_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    // ------------------------------
    // Stimulus file
    // ------------------------------
    task automatic load_stim();
        int        fd;
        int        code;
        string     tok;
        string     rest;
        wb_addr_t  a;
        wb_data_t  d;
        wb_sel_t   s;
        wb_data_t  e;
        logic      ee;
        fd = $fopen("tb/digital_core_stim.txt", "r");
        if (fd == 0) begin
            $display("Cannot open stimulus file tb/digital_core_stim.txt");
            n_errors++;
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %s", tok);
            if (code != 1) break;
            if (tok[0] == "#") begin
                code = $fgets(rest, fd);    // Drop the rest of a comment line
            end else begin
                code = $fscanf(fd, " %h %h %h %h %h", a, d, s, e, ee);
                if (code != 5) begin
                    $display("Malformed stimulus line after op %s", tok);
                    n_errors++;
                    break;
                end
                op_q.push_back(tok[0]);
                adr_q.push_back(a);
                dat_q.push_back(d);
                sel_q.push_back(s);
                exp_q.push_back(e);
                eerr_q.push_back(ee);
            end
        end
        $fclose(fd);
        n_lines = op_q.size();
    endtask

    // ------------------------------
    // Register model
    // ------------------------------
    task automatic model_write(input reg_addr_t off, input wb_data_t d, input wb_sel_t s);
        wb_data_t mask;
        mask = {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};   // Byte lanes
        case (off)
            GLBL_CTRL:   ctrl_m   = ((ctrl_m & ~mask) | (d & mask)) & 32'h7;
            GLBL_IRQ:    irq_m    = ((irq_m & ~mask) | (d & mask)) & 32'h7;
            GLBL_HARTID: hartid_m = (hartid_m & ~mask) | (d & mask);
            default: ;  // IDCODE and holes keep nothing
        endcase
    endtask

    function automatic wb_data_t model_read(input reg_addr_t off);
        case (off)
            GLBL_CTRL:   return ctrl_m;
            GLBL_IRQ:    return irq_m;
            GLBL_HARTID: return hartid_m;
            GLBL_IDCODE: return `DEVICE_IDCODE;
            default:     return '0;
        endcase
    endfunction

    // One Wishbone transfer, falling edges counted until ack or err
    task automatic bus_xfer(
        input  logic     wr,
        input  wb_addr_t a,
        input  wb_data_t d,
        input  wb_sel_t  s,
        output wb_data_t rd,
        output logic     got_ack,
        output logic     got_err,
        output int       cycles
    );
        rd      = '0;
        got_ack = 1'b0;
        got_err = 1'b0;
        cycles  = 0;
        @(posedge clk);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= wr;
        adr   <= a;
        dat_w <= d;
        sel   <= s;
        while (!(got_ack || got_err) && cycles < RSP_LIMIT) begin
            @(negedge clk);     // Outputs settled mid cycle
            cycles++;
            got_ack = ack;
            got_err = err;
            rd      = dat_r;
        end
        if (!(got_ack || got_err)) begin
            $display("No response from the DUT within %0d cycles at address 0x%08h",
                     RSP_LIMIT, a);
            n_errors++;
        end
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
    endtask

    task automatic run_line(input int idx);
        byte       op;
        wb_addr_t  a;
        wb_data_t  d;
        wb_data_t  rd;
        logic      got_ack;
        logic      got_err;
        logic      wr;
        int        cycles;
        op = op_q[idx];
        a  = adr_q[idx];
        d  = dat_q[idx];
        if (op == "P") begin
            @(negedge clk);
            check_val("block_ports", {{(32-`USER_IRQ_W-4){1'b0}}, user_irq, 1'b0,
                      sdram_rst_n, spi_rst_n, cpu_rst_n}, exp_q[idx]);
            return;
        end
        if (op == "Q") d = $random(seed);   // Random write data
        wr = (op == "W") || (op == "Q");
        bus_xfer(wr, a, d, sel_q[idx], rd, got_ack, got_err, cycles);
        // Seen half a cycle after the rising edge that raised it
        check_val("response_latency", 32'(cycles - 1), 32'd2);
        check_val("wbd_ext_err_o", 32'(got_err), 32'(eerr_q[idx]));
        check_val("wbd_ext_ack_o", 32'(got_ack), 32'(!eerr_q[idx]));
        if (eerr_q[idx]) check_val("wbd_ext_dat_o", rd, '0);
        else if (op == "R") check_val("wbd_ext_dat_o", rd, exp_q[idx]);
        else if (op == "M") check_val("wbd_ext_dat_o", rd, model_read(a[5:2]));
        if (wr && a[31:28] == `GLBL_BASE_NIB) model_write(a[5:2], d, sel_q[idx]);
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        rst_n    = 1'b0;
        cyc      = 1'b0;
        stb      = 1'b0;
        we       = 1'b0;
        adr      = '0;
        dat_w    = '0;
        sel      = '0;
        seed     = 78712;
        ctrl_m   = '0;
        irq_m    = '0;
        hartid_m = `HARTID_RST;
        load_stim();
        loaded = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < n_lines; i++) begin
            run_line(i);
        end
        repeat (2) @(posedge clk);
        if (DUT.u_checker.fail_cnt != 0) begin
            $display("Bound checker saw %0d assertion failures", DUT.u_checker.fail_cnt);
            n_errors += DUT.u_checker.fail_cnt;
        end
        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Watchdog, sized from the stimulus length
    initial begin
        wait (loaded);
        repeat (n_lines * LINE_BUDGET + RST_CYCLES) @(posedge clk);
        $display("Timeout: stimulus did not finish within %0d cycles",
                 n_lines * LINE_BUDGET + RST_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

endmodule : tb_digital_core
